//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alu.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_config.svh"

module alu import ctrl_pkg::*; (
	input  logic [3:0]             alu_op,
	input  logic [`DATA_WIDTH-1:0] op1,
	input  logic [`DATA_WIDTH-1:0] op2,
	output logic [`DATA_WIDTH-1:0] result,
	output logic                   cond
);

	logic [4:0] shamt;

	assign shamt = op2[4:0]; // shifts use low 5 bits only

	always_comb begin
		result = '0;
		cond   = 1'b0;
		case (alu_op)
			ALU_SLL: result = op1 << shamt;
			ALU_SRL: result = op1 >> shamt;
			ALU_SRA: result = $signed(op1) >>> shamt;
			ALU_ADD: result = op1 + op2;
			ALU_SUB: result = op1 - op2;
			ALU_AND: result = op1 & op2;
			ALU_OR:  result = op1 | op2;
			ALU_XOR: result = op1 ^ op2;
			ALU_SLT: begin
				result    = '0;
				result[0] = ($signed(op1) < $signed(op2)); // signed compare
			end
			ALU_EQ: cond = (op1 == op2);
			ALU_NE: cond = (op1 != op2);
			default: begin
				result = '0;
				cond   = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath word width
`define DATA_WIDTH 32

// register index width, 32 entries
`define REG_ADDR_WIDTH 5

// jal writes its return address here
`define LINK_REG 5'd31

// pc value after reset
`define RESET_PC 32'h0000_0000

`endif

//--- cpu_core.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_core import isa_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  instr_t                     instr,
	input  logic                       instr_valid,
	input  logic [`DATA_WIDTH-1:0]     mem_rdata,
	input  logic [7:0]                 uart_rx_data,
	output logic [`DATA_WIDTH-1:0]     pc,
	output logic                       wb_en,
	output logic [`REG_ADDR_WIDTH-1:0] wb_addr,
	output logic [`DATA_WIDTH-1:0]     wb_data,
	output logic                       mem_we,
	output logic                       mem_re,
	output logic [`DATA_WIDTH-1:0]     mem_addr,
	output logic [`DATA_WIDTH-1:0]     mem_wdata,
	output logic                       uart_tx_valid,
	output logic [7:0]                 uart_tx_data
);

	logic                   reg_write;
	logic [1:0]             mem_to_reg;
	logic [1:0]             alu_srcs;
	logic                   alu_srcs2;
	logic [3:0]             alu_op;
	logic [1:0]             reg_dist;
	logic [1:0]             branch;
	logic                   mem_write;
	logic                   mem_read;
	logic                   uart_to_reg;
	logic                   reg_to_uart;
	logic [`DATA_WIDTH-1:0] rs_data;
	logic [`DATA_WIDTH-1:0] rt_data;
	logic [`DATA_WIDTH-1:0] next_pc;

	// pc only moves on strobed cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (instr_valid) begin
			pc <= next_pc;
		end
	end

	operator u_operator (
		.opcode      (instr.r.opcode),
		.funct       (instr.r.funct),
		.reg_write   (reg_write),
		.mem_to_reg  (mem_to_reg),
		.alu_srcs    (alu_srcs),
		.alu_srcs2   (alu_srcs2),
		.alu_op      (alu_op),
		.reg_dist    (reg_dist),
		.branch      (branch),
		.mem_write   (mem_write),
		.mem_read    (mem_read),
		.uart_to_reg (uart_to_reg),
		.reg_to_uart (reg_to_uart)
	);

	register_file u_register_file (
		.clk     (clk),
		.reset   (reset),
		.rs_addr (instr.r.rs),
		.rt_addr (instr.r.rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	execute_unit u_execute_unit (
		.instr         (instr),
		.pc            (pc),
		.rs_data       (rs_data),
		.rt_data       (rt_data),
		.reg_write     (reg_write),
		.mem_to_reg    (mem_to_reg),
		.alu_srcs      (alu_srcs),
		.alu_srcs2     (alu_srcs2),
		.alu_op        (alu_op),
		.reg_dist      (reg_dist),
		.branch        (branch),
		.mem_write     (mem_write),
		.mem_read      (mem_read),
		.uart_to_reg   (uart_to_reg),
		.reg_to_uart   (reg_to_uart),
		.instr_valid   (instr_valid),
		.mem_rdata     (mem_rdata),
		.uart_rx_data  (uart_rx_data),
		.wb_en         (wb_en),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.next_pc       (next_pc),
		.mem_we        (mem_we),
		.mem_re        (mem_re),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.uart_tx_valid (uart_tx_valid),
		.uart_tx_data  (uart_tx_data)
	);

endmodule

`default_nettype wire

//--- cpu_core_checker.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_core_checker (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       instr_valid,
	input  logic [`DATA_WIDTH-1:0]     pc,
	input  logic                       wb_en,
	input  logic [`REG_ADDR_WIDTH-1:0] wb_addr,
	input  logic                       mem_we,
	input  logic                       mem_re,
	input  logic                       uart_tx_valid
);

	int assert_failures;

	initial assert_failures = 0;

	// strobes only ride on a valid instruction
	a_strobe_gated: assert property (@(posedge clk)
			!instr_valid |-> !(mem_we || mem_re || uart_tx_valid))
		else begin
			$error("memory or uart strobe high without instr_valid");
			assert_failures++;
		end

	a_mem_exclusive: assert property (@(posedge clk) !(mem_we && mem_re))
		else begin
			$error("mem_we and mem_re high together");
			assert_failures++;
		end

	a_no_r0_write: assert property (@(posedge clk) wb_en |-> (wb_addr != '0))
		else begin
			$error("writeback enabled for register zero");
			assert_failures++;
		end

	a_reset_pc: assert property (@(posedge clk) reset |=> (pc == `RESET_PC))
		else begin
			$error("pc not at reset value after reset");
			assert_failures++;
		end

endmodule

`default_nettype wire

//--- ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// alu operation codes
	localparam logic [3:0] ALU_SLL  = 4'b0000;
	localparam logic [3:0] ALU_SRL  = 4'b0001;
	localparam logic [3:0] ALU_SRA  = 4'b0010;
	localparam logic [3:0] ALU_ADD  = 4'b0011;
	localparam logic [3:0] ALU_SUB  = 4'b0100;
	localparam logic [3:0] ALU_AND  = 4'b0101;
	localparam logic [3:0] ALU_OR   = 4'b0110;
	localparam logic [3:0] ALU_XOR  = 4'b0111;
	localparam logic [3:0] ALU_SLT  = 4'b1000;
	localparam logic [3:0] ALU_EQ   = 4'b1001; // beq compare
	localparam logic [3:0] ALU_NE   = 4'b1010; // bne compare
	localparam logic [3:0] ALU_NONE = 4'b1111;

	// mem_to_reg, writeback data source
	localparam logic [1:0] MTR_MEM = 2'b01;
	localparam logic [1:0] MTR_ALU = 2'b10;
	localparam logic [1:0] MTR_PC  = 2'b11; // pc+4 for jal

	// alu_srcs, second operand
	localparam logic [1:0] SRC_RT    = 2'b00;
	localparam logic [1:0] SRC_SHAMT = 2'b01;
	localparam logic [1:0] SRC_IMM   = 2'b10;
	localparam logic [1:0] SRC_NONE  = 2'b11;

	// alu_srcs2, first operand
	localparam logic OP1_RT = 1'b0;
	localparam logic OP1_RS = 1'b1;

	// reg_dist, destination register
	localparam logic [1:0] DST_RD   = 2'b00;
	localparam logic [1:0] DST_RT   = 2'b01;
	localparam logic [1:0] DST_LINK = 2'b10;
	localparam logic [1:0] DST_NONE = 2'b11;

	// branch, next pc source
	localparam logic [1:0] BR_REG  = 2'b00; // jr
	localparam logic [1:0] BR_JUMP = 2'b01; // j, jal
	localparam logic [1:0] BR_COND = 2'b10; // beq, bne
	localparam logic [1:0] BR_SEQ  = 2'b11;

endpackage

`default_nettype wire

//--- execute_unit.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_config.svh"

module execute_unit import isa_pkg::*, ctrl_pkg::*; (
	input  instr_t                     instr,
	input  logic [`DATA_WIDTH-1:0]     pc,
	input  logic [`DATA_WIDTH-1:0]     rs_data,
	input  logic [`DATA_WIDTH-1:0]     rt_data,
	input  logic                       reg_write,
	input  logic [1:0]                 mem_to_reg,
	input  logic [1:0]                 alu_srcs,
	input  logic                       alu_srcs2,
	input  logic [3:0]                 alu_op,
	input  logic [1:0]                 reg_dist,
	input  logic [1:0]                 branch,
	input  logic                       mem_write,
	input  logic                       mem_read,
	input  logic                       uart_to_reg,
	input  logic                       reg_to_uart,
	input  logic                       instr_valid,
	input  logic [`DATA_WIDTH-1:0]     mem_rdata,
	input  logic [7:0]                 uart_rx_data,
	output logic                       wb_en,
	output logic [`REG_ADDR_WIDTH-1:0] wb_addr,
	output logic [`DATA_WIDTH-1:0]     wb_data,
	output logic [`DATA_WIDTH-1:0]     next_pc,
	output logic                       mem_we,
	output logic                       mem_re,
	output logic [`DATA_WIDTH-1:0]     mem_addr,
	output logic [`DATA_WIDTH-1:0]     mem_wdata,
	output logic                       uart_tx_valid,
	output logic [7:0]                 uart_tx_data
);

	logic [`DATA_WIDTH-1:0] op1;
	logic [`DATA_WIDTH-1:0] op2;
	logic [`DATA_WIDTH-1:0] alu_result;
	logic                   cond;
	logic [`DATA_WIDTH-1:0] imm_ext;
	logic [`DATA_WIDTH-1:0] pc_plus4;
	logic [`DATA_WIDTH-1:0] br_target;
	logic [`DATA_WIDTH-1:0] jump_target;

	assign pc_plus4    = pc + `DATA_WIDTH'd4;
	assign imm_ext     = {{(`DATA_WIDTH-16){instr.i.imm[15]}}, instr.i.imm};
	assign br_target   = pc_plus4 + {imm_ext[`DATA_WIDTH-3:0], 2'b00}; // word offset
	assign jump_target = {pc_plus4[`DATA_WIDTH-1:28], instr.j.target, 2'b00};

	assign op1 = (alu_srcs2 == OP1_RS) ? rs_data : rt_data;

	always_comb begin
		case (alu_srcs)
			SRC_RT:    op2 = rt_data;
			SRC_SHAMT: op2 = {{(`DATA_WIDTH-5){1'b0}}, instr.r.shamt};
			SRC_IMM:   op2 = imm_ext;
			default:   op2 = '0;
		endcase
	end

	alu u_alu (
		.alu_op (alu_op),
		.op1    (op1),
		.op2    (op2),
		.result (alu_result),
		.cond   (cond)
	);

	always_comb begin
		case (reg_dist)
			DST_RT:   wb_addr = instr.i.rt;
			DST_LINK: wb_addr = `LINK_REG;
			default:  wb_addr = instr.r.rd;
		endcase
	end

	always_comb begin
		if (uart_to_reg) begin
			wb_data = {{(`DATA_WIDTH-8){1'b0}}, uart_rx_data}; // in, zero-extended byte
		end else begin
			case (mem_to_reg)
				MTR_MEM: wb_data = mem_rdata;
				MTR_PC:  wb_data = pc_plus4;
				default: wb_data = alu_result;
			endcase
		end
	end

	always_comb begin
		case (branch)
			BR_REG:  next_pc = rs_data;
			BR_JUMP: next_pc = jump_target;
			BR_COND: next_pc = cond ? br_target : pc_plus4;
			default: next_pc = pc_plus4;
		endcase
	end

	assign wb_en = instr_valid & reg_write & (wb_addr != '0); // r0 never written

	assign mem_we    = instr_valid & mem_write;
	assign mem_re    = instr_valid & mem_read;
	assign mem_addr  = alu_result;
	assign mem_wdata = rt_data;

	assign uart_tx_valid = instr_valid & reg_to_uart;
	assign uart_tx_data  = rt_data[7:0];

endmodule

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

	// opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000; // r-type, decoded by funct
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_SW      = 6'b101011;
	localparam logic [5:0] OP_IN      = 6'b111011; // uart byte to rt
	localparam logic [5:0] OP_OUT     = 6'b111100; // rt low byte to uart

	// funct field of r-type
	localparam logic [5:0] FUNCT_SLL = 6'b000000;
	localparam logic [5:0] FUNCT_SRL = 6'b000010;
	localparam logic [5:0] FUNCT_SRA = 6'b000011;
	localparam logic [5:0] FUNCT_JR  = 6'b001000;
	localparam logic [5:0] FUNCT_ADD = 6'b100000;
	localparam logic [5:0] FUNCT_SUB = 6'b100010;
	localparam logic [5:0] FUNCT_AND = 6'b100100;
	localparam logic [5:0] FUNCT_OR  = 6'b100101;
	localparam logic [5:0] FUNCT_XOR = 6'b100110;
	localparam logic [5:0] FUNCT_SLT = 6'b101010;

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] target;
		} j;
	} instr_t;

endpackage

`default_nettype wire

//--- list.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
operator.sv
register_file.sv
alu.sv
execute_unit.sv
cpu_core.sv
cpu_core_checker.sv
tb_cpu_core.sv

//--- operator.sv
`default_nettype none
`timescale 1ns/10ps

module operator import isa_pkg::*, ctrl_pkg::*; (
	input  logic [5:0] opcode,
	input  logic [5:0] funct,
	output logic       reg_write,
	output logic [1:0] mem_to_reg,
	output logic [1:0] alu_srcs,
	output logic       alu_srcs2,
	output logic [3:0] alu_op,
	output logic [1:0] reg_dist,
	output logic [1:0] branch,
	output logic       mem_write,
	output logic       mem_read,
	output logic       uart_to_reg,
	output logic       reg_to_uart
);

	always_comb begin
		reg_write   = 1'b0; // no-op word, pc just advances
		mem_to_reg  = MTR_ALU;
		alu_srcs    = SRC_NONE;
		alu_srcs2   = OP1_RS;
		alu_op      = ALU_NONE;
		reg_dist    = DST_NONE;
		branch      = BR_SEQ;
		mem_write   = 1'b0;
		mem_read    = 1'b0;
		uart_to_reg = 1'b0;
		reg_to_uart = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FUNCT_SLL: alu_op = ALU_SLL;
					FUNCT_SRL: alu_op = ALU_SRL;
					FUNCT_SRA: alu_op = ALU_SRA;
					FUNCT_JR:  alu_op = ALU_ADD;
					FUNCT_ADD: alu_op = ALU_ADD;
					FUNCT_SUB: alu_op = ALU_SUB;
					FUNCT_AND: alu_op = ALU_AND;
					FUNCT_OR:  alu_op = ALU_OR;
					FUNCT_XOR: alu_op = ALU_XOR;
					FUNCT_SLT: alu_op = ALU_SLT;
					default:   alu_op = ALU_NONE;
				endcase
				case (funct)
					FUNCT_SLL, FUNCT_SRL, FUNCT_SRA: begin
						reg_write = 1'b1;
						alu_srcs  = SRC_SHAMT; // shift rt by shamt
						alu_srcs2 = OP1_RT;
						reg_dist  = DST_RD;
					end
					FUNCT_JR: begin
						alu_srcs = SRC_RT;
						branch   = BR_REG;
					end
					FUNCT_ADD, FUNCT_SUB, FUNCT_AND, FUNCT_OR, FUNCT_XOR, FUNCT_SLT: begin
						reg_write = 1'b1;
						alu_srcs  = SRC_RT;
						reg_dist  = DST_RD;
					end
					default: begin
					end
				endcase
			end
			OP_J: branch = BR_JUMP;
			OP_JAL: begin
				reg_write  = 1'b1;
				mem_to_reg = MTR_PC; // return address
				reg_dist   = DST_LINK;
				branch     = BR_JUMP;
			end
			OP_BEQ, OP_BNE: begin
				alu_srcs = SRC_RT;
				alu_op   = (opcode == OP_BEQ) ? ALU_EQ : ALU_NE;
				branch   = BR_COND;
			end
			OP_ADDI, OP_ANDI, OP_ORI: begin
				reg_write = 1'b1;
				alu_srcs  = SRC_IMM;
				reg_dist  = DST_RT;
				case (opcode)
					OP_ANDI: alu_op = ALU_AND;
					OP_ORI:  alu_op = ALU_OR;
					default: alu_op = ALU_ADD;
				endcase
			end
			OP_LW: begin
				reg_write  = 1'b1;
				mem_to_reg = MTR_MEM;
				alu_srcs   = SRC_IMM; // rs + offset
				alu_op     = ALU_ADD;
				reg_dist   = DST_RT;
				mem_read   = 1'b1;
			end
			OP_SW: begin
				alu_srcs  = SRC_IMM;
				alu_op    = ALU_ADD;
				mem_write = 1'b1;
			end
			OP_IN: begin
				reg_write   = 1'b1;
				reg_dist    = DST_RT;
				uart_to_reg = 1'b1;
			end
			OP_OUT: reg_to_uart = 1'b1;
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- register_file.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_config.svh"

module register_file (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`REG_ADDR_WIDTH-1:0] rs_addr,
	input  logic [`REG_ADDR_WIDTH-1:0] rt_addr,
	output logic [`DATA_WIDTH-1:0]     rs_data,
	output logic [`DATA_WIDTH-1:0]     rt_data,
	input  logic                       wb_en,
	input  logic [`REG_ADDR_WIDTH-1:0] wb_addr,
	input  logic [`DATA_WIDTH-1:0]     wb_data
);

	localparam int NUM_REGS = 2 ** `REG_ADDR_WIDTH;

	logic [`DATA_WIDTH-1:0] regs [0:NUM_REGS-1];

	// writes to r0 are dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && (wb_addr != '0)) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// r0 reads as zero
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- tb_cpu_core.sv
`default_nettype none
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu_core import isa_pkg::*; ();

	localparam int MEM_WORDS   = 64;
	localparam int N_ARITH     = 200;
	localparam int N_MEM       = 120;
	localparam int N_FLOW      = 150;
	localparam int N_UART      = 60;
	localparam int N_UNDEF     = 90;
	localparam int TOTAL_STEPS = 10 + 2 + 31 + N_ARITH + N_MEM + N_FLOW + N_UART + N_UNDEF;
	localparam int WATCHDOG_NS = TOTAL_STEPS * 40 + 2000;

	logic                       clk;
	logic                       reset;
	instr_t                     instr;
	logic                       instr_valid;
	logic [`DATA_WIDTH-1:0]     mem_rdata;
	logic [7:0]                 uart_rx_data;
	logic [`DATA_WIDTH-1:0]     pc;
	logic                       wb_en;
	logic [`REG_ADDR_WIDTH-1:0] wb_addr;
	logic [`DATA_WIDTH-1:0]     wb_data;
	logic                       mem_we;
	logic                       mem_re;
	logic [`DATA_WIDTH-1:0]     mem_addr;
	logic [`DATA_WIDTH-1:0]     mem_wdata;
	logic                       uart_tx_valid;
	logic [7:0]                 uart_tx_data;

	logic [`DATA_WIDTH-1:0] model_regs [0:31];
	logic [`DATA_WIDTH-1:0] data_mem [0:MEM_WORDS-1]; // shared by model and external memory
	logic [`DATA_WIDTH-1:0] model_pc;

	logic                       exp_wb_en;
	logic [`REG_ADDR_WIDTH-1:0] exp_wb_addr;
	logic [`DATA_WIDTH-1:0]     exp_wb_data;
	logic [`DATA_WIDTH-1:0]     exp_next_pc;
	logic                       exp_mem_we;
	logic                       exp_mem_re;
	logic [`DATA_WIDTH-1:0]     exp_mem_addr;
	logic [`DATA_WIDTH-1:0]     exp_mem_wdata;
	logic                       exp_tx_valid;
	logic [7:0]                 exp_tx_data;

	int          check_count;
	int          error_count;
	int          test_errors;
	int          test_steps;
	string       test_name;

	cpu_core dut (
		.clk           (clk),
		.reset         (reset),
		.instr         (instr),
		.instr_valid   (instr_valid),
		.mem_rdata     (mem_rdata),
		.uart_rx_data  (uart_rx_data),
		.pc            (pc),
		.wb_en         (wb_en),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.mem_we        (mem_we),
		.mem_re        (mem_re),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.uart_tx_valid (uart_tx_valid),
		.uart_tx_data  (uart_tx_data)
	);

	bind cpu_core cpu_core_checker u_checker (
		.clk           (clk),
		.reset         (reset),
		.instr_valid   (instr_valid),
		.pc            (pc),
		.wb_en         (wb_en),
		.wb_addr       (wb_addr),
		.mem_we        (mem_we),
		.mem_re        (mem_re),
		.uart_tx_valid (uart_tx_valid)
	);

	assign mem_rdata = data_mem[mem_addr[7:2]]; // word index wraps at MEM_WORDS

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic report_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		error_count++;
		test_errors++;
		$display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic check_word(input string what, input logic [`DATA_WIDTH-1:0] got,
			input logic [`DATA_WIDTH-1:0] exp);
		check_count++;
		if (got !== exp) report_mismatch(what, got, exp);
	endtask

	task automatic check_index(input string what, input logic [`REG_ADDR_WIDTH-1:0] got,
			input logic [`REG_ADDR_WIDTH-1:0] exp);
		check_count++;
		if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		check_count++;
		if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		check_count++;
		if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic check_target(input string what, input logic [25:0] got,
			input logic [25:0] exp);
		check_count++;
		if (got !== exp) report_mismatch(what, 32'(got), 32'(exp));
	endtask

	task automatic expect_write(input logic [`REG_ADDR_WIDTH-1:0] addr,
			input logic [`DATA_WIDTH-1:0] data);
		exp_wb_en   = (addr != '0); // r0 is never written
		exp_wb_addr = addr;
		exp_wb_data = data;
	endtask

	// reference model of one instruction
	task automatic predict(input instr_t ins, input logic valid);
		logic [`DATA_WIDTH-1:0] rs_v;
		logic [`DATA_WIDTH-1:0] rt_v;
		logic [`DATA_WIDTH-1:0] simm;
		logic [`DATA_WIDTH-1:0] pc4;
		rs_v = model_regs[ins.r.rs];
		rt_v = model_regs[ins.r.rt];
		simm = {{(`DATA_WIDTH-16){ins.i.imm[15]}}, ins.i.imm};
		pc4  = model_pc + 32'd4;
		exp_wb_en     = 1'b0;
		exp_wb_addr   = '0;
		exp_wb_data   = '0;
		exp_next_pc   = pc4;
		exp_mem_we    = 1'b0;
		exp_mem_re    = 1'b0;
		exp_mem_addr  = '0;
		exp_mem_wdata = '0;
		exp_tx_valid  = 1'b0;
		exp_tx_data   = '0;
		case (ins.r.opcode)
			OP_SPECIAL: begin
				case (ins.r.funct)
					FUNCT_SLL: expect_write(ins.r.rd, rt_v << ins.r.shamt);
					FUNCT_SRL: expect_write(ins.r.rd, rt_v >> ins.r.shamt);
					FUNCT_SRA: expect_write(ins.r.rd, $signed(rt_v) >>> ins.r.shamt);
					FUNCT_ADD: expect_write(ins.r.rd, rs_v + rt_v);
					FUNCT_SUB: expect_write(ins.r.rd, rs_v - rt_v);
					FUNCT_AND: expect_write(ins.r.rd, rs_v & rt_v);
					FUNCT_OR:  expect_write(ins.r.rd, rs_v | rt_v);
					FUNCT_XOR: expect_write(ins.r.rd, rs_v ^ rt_v);
					FUNCT_SLT: expect_write(ins.r.rd,
							{{(`DATA_WIDTH-1){1'b0}}, ($signed(rs_v) < $signed(rt_v))});
					FUNCT_JR:  exp_next_pc = rs_v;
					default: begin
					end
				endcase
			end
			OP_J:   exp_next_pc = {pc4[31:28], ins.j.target, 2'b00};
			OP_JAL: begin
				exp_next_pc = {pc4[31:28], ins.j.target, 2'b00};
				expect_write(`LINK_REG, pc4); // return address
			end
			OP_BEQ: if (rs_v == rt_v) exp_next_pc = pc4 + (simm << 2);
			OP_BNE: if (rs_v != rt_v) exp_next_pc = pc4 + (simm << 2);
			OP_ADDI: expect_write(ins.i.rt, rs_v + simm);
			OP_ANDI: expect_write(ins.i.rt, rs_v & simm);
			OP_ORI:  expect_write(ins.i.rt, rs_v | simm);
			OP_LW: begin
				exp_mem_re   = 1'b1;
				exp_mem_addr = rs_v + simm;
				expect_write(ins.i.rt, data_mem[exp_mem_addr[7:2]]);
			end
			OP_SW: begin
				exp_mem_we    = 1'b1;
				exp_mem_addr  = rs_v + simm;
				exp_mem_wdata = rt_v;
			end
			OP_IN: expect_write(ins.i.rt, {{(`DATA_WIDTH-8){1'b0}}, uart_rx_data});
			OP_OUT: begin
				exp_tx_valid = 1'b1;
				exp_tx_data  = rt_v[7:0];
			end
			default: begin
			end
		endcase
		if (!valid) begin // idle cycle changes nothing
			exp_wb_en    = 1'b0;
			exp_mem_we   = 1'b0;
			exp_mem_re   = 1'b0;
			exp_tx_valid = 1'b0;
			exp_next_pc  = model_pc;
		end
	endtask

	task automatic commit();
		if (exp_wb_en) model_regs[exp_wb_addr] = exp_wb_data;
		if (exp_mem_we) data_mem[exp_mem_addr[7:2]] = exp_mem_wdata;
		model_pc = exp_next_pc;
	endtask

	task automatic check_outputs();
		check_word("pc", pc, model_pc);
		check_bit("wb_en", wb_en, exp_wb_en);
		if (exp_wb_en) begin
			check_index("wb_addr", wb_addr, exp_wb_addr);
			check_word("wb_data", wb_data, exp_wb_data);
		end
		check_bit("mem_we", mem_we, exp_mem_we);
		check_bit("mem_re", mem_re, exp_mem_re);
		if (exp_mem_we || exp_mem_re) check_word("mem_addr", mem_addr, exp_mem_addr);
		if (exp_mem_we) check_word("mem_wdata", mem_wdata, exp_mem_wdata);
		check_bit("uart_tx_valid", uart_tx_valid, exp_tx_valid);
		if (exp_tx_valid) check_byte("uart_tx_data", uart_tx_data, exp_tx_data);
	endtask

	// one clock cycle from 2 ns after a rising edge to 2 ns after the next
	task automatic step(input instr_t ins, input logic valid);
		instr        = ins;
		instr_valid  = valid;
		uart_rx_data = 8'($urandom);
		predict(ins, valid);
		@(negedge clk);
		check_outputs();
		@(posedge clk);
		if (valid) commit();
		#2;
		if (valid && (ins.j.opcode == OP_J || ins.j.opcode == OP_JAL)) begin
			check_target("jump target", pc[27:2], ins.j.target);
		end
		test_steps++;
	endtask

	function automatic instr_t rand_arith();
		instr_t w;
		w = $urandom;
		w.r.opcode = OP_SPECIAL;
		case ($urandom % 12)
			0: w.r.funct = FUNCT_SLL;
			1: w.r.funct = FUNCT_SRL;
			2: w.r.funct = FUNCT_SRA;
			3: w.r.funct = FUNCT_ADD;
			4: w.r.funct = FUNCT_SUB;
			5: w.r.funct = FUNCT_AND;
			6: w.r.funct = FUNCT_OR;
			7: w.r.funct = FUNCT_XOR;
			8: w.r.funct = FUNCT_SLT;
			9: w.i.opcode = OP_ADDI;
			10: w.i.opcode = OP_ANDI;
			default: w.i.opcode = OP_ORI;
		endcase
		return w;
	endfunction

	function automatic instr_t rand_mem();
		instr_t w;
		w = $urandom;
		w.i.opcode = ($urandom % 2 == 0) ? OP_LW : OP_SW;
		w.i.rs     = '0; // base r0 keeps addresses small
		w.i.imm    = 16'(($urandom % MEM_WORDS) * 4);
		return w;
	endfunction

	function automatic instr_t rand_flow();
		instr_t w;
		w = $urandom;
		case ($urandom % 6)
			0: w.i.opcode = OP_BEQ;
			1: w.i.opcode = OP_BNE;
			2: begin
				w.i.opcode = ($urandom % 2 == 0) ? OP_BEQ : OP_BNE;
				w.i.rt     = w.i.rs; // equal operands
			end
			3: w.j.opcode = OP_J;
			4: w.j.opcode = OP_JAL;
			default: begin
				w.r.opcode = OP_SPECIAL;
				w.r.funct  = FUNCT_JR;
			end
		endcase
		return w;
	endfunction

	function automatic instr_t rand_uart();
		instr_t w;
		w = $urandom;
		w.i.opcode = ($urandom % 2 == 0) ? OP_IN : OP_OUT;
		return w;
	endfunction

	function automatic instr_t rand_undef();
		instr_t w;
		w = $urandom;
		if ($urandom % 2 == 0) begin
			w.r.opcode = OP_SPECIAL;
			while (w.r.funct inside {FUNCT_SLL, FUNCT_SRL, FUNCT_SRA, FUNCT_JR, FUNCT_ADD,
					FUNCT_SUB, FUNCT_AND, FUNCT_OR, FUNCT_XOR, FUNCT_SLT}) begin
				w.r.funct = 6'($urandom);
			end
		end else begin
			while (w.r.opcode inside {OP_SPECIAL, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDI,
					OP_ANDI, OP_ORI, OP_LW, OP_SW, OP_IN, OP_OUT}) begin
				w.r.opcode = 6'($urandom);
			end
		end
		return w;
	endfunction

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
		test_steps  = 0;
	endtask

	task automatic finish_test();
		$display("test %-6s done: %0d instructions, %0d errors", test_name, test_steps,
				test_errors);
	endtask

	task automatic test_reset();
		instr_t ins;
		start_test("reset");
		check_word("pc after reset", pc, `RESET_PC);
		check_bit("wb_en after reset", wb_en, 1'b0);
		check_bit("mem_we after reset", mem_we, 1'b0);
		check_bit("mem_re after reset", mem_re, 1'b0);
		check_bit("uart_tx_valid after reset", uart_tx_valid, 1'b0);
		ins          = '0;
		ins.r.opcode = OP_SPECIAL;
		ins.r.rd     = 5'd5;
		ins.r.funct  = FUNCT_ADD;
		step(ins, 1'b1);
		ins.r.rs = 5'd7; // r7 still holds zero from reset
		ins.r.rd = 5'd9;
		step(ins, 1'b1);
		finish_test();
	endtask

	task automatic test_arith();
		instr_t ins;
		start_test("arith");
		for (int r = 1; r < 32; r++) begin
			ins.i.opcode = OP_ADDI;
			ins.i.rs     = '0;
			ins.i.rt     = 5'(r);
			ins.i.imm    = 16'($urandom);
			step(ins, 1'b1);
		end
		repeat (N_ARITH) step(rand_arith(), 1'b1);
		finish_test();
	endtask

	task automatic test_mem();
		start_test("mem");
		repeat (N_MEM) step(rand_mem(), 1'b1);
		finish_test();
	endtask

	task automatic test_flow();
		start_test("flow");
		repeat (N_FLOW) step(rand_flow(), 1'b1);
		finish_test();
	endtask

	task automatic test_uart();
		start_test("uart");
		repeat (N_UART) step(rand_uart(), 1'b1);
		finish_test();
	endtask

	task automatic test_undef();
		start_test("undef");
		repeat (N_UNDEF) begin
			case ($urandom % 4)
				0: step(rand_undef(), 1'b1);
				1: step(rand_mem(), 1'b0); // idle with a load or store on the bus
				2: step(rand_uart(), 1'b0);
				default: step(rand_arith(), 1'b1);
			endcase
		end
		finish_test();
	endtask

	initial begin
		void'($urandom(65888));
		reset        = 1'b1;
		instr        = '0;
		instr_valid  = 1'b0;
		uart_rx_data = '0;
		check_count  = 0;
		error_count  = 0;
		model_pc     = `RESET_PC;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			data_mem[i] = (32'(i) * 32'h9E37_79B9) ^ {16'h5A5A, 16'(i)};
		end
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		test_reset();
		test_arith();
		test_mem();
		test_flow();
		test_uart();
		test_undef();
		error_count += dut.u_checker.assert_failures;
		$display("summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
